/* sim.f */
+incdir+.
split_pkg.sv
axis_beat_if.sv
stream_split_channel.sv
axis_skid_buffer.sv
stream_split_top.sv
tb_stream_split.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_stream_split
FILELIST  := sim.f

SOURCES := $(wildcard *.sv) $(wildcard *.svh)
SIM     := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only when the testbench prints its pass line.
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

/* tb_split_table.svh */
`ifndef TB_SPLIT_TABLE_SVH
`define TB_SPLIT_TABLE_SVH

// one row per packet.
// columns: packet length, split length, first ready %, end ready %,
// expected first beats, expected end beats.
typedef struct packed {
    int pkt_len;
    int split;
    int first_pct;
    int end_pct;
    int first_cnt;
    int end_cnt;
} row_t;

localparam int NUM_ROWS = 21;

row_t rows [NUM_ROWS];

task automatic load_table();
    // plain splits with free-running outputs.
    rows[0]  = '{8, 3, 100, 100, 3, 5};
    rows[1]  = '{5, 1, 100, 100, 1, 4};
    rows[2]  = '{6, 5, 100, 100, 5, 1};

    // edge lengths.
    rows[3]  = '{7, 0, 100, 100, 0, 7};   // all to the end side.
    rows[4]  = '{4, 4, 100, 100, 4, 0};   // split equals length.
    rows[5]  = '{3, 9, 100, 100, 3, 0};   // split beyond length.
    rows[6]  = '{1, 0, 100, 100, 0, 1};
    rows[7]  = '{1, 1, 100, 100, 1, 0};
    rows[8]  = '{1, 5, 70, 70, 1, 0};

    // long packets with the reference ready patterns.
    rows[9]  = '{50, 100, 30, 100, 50, 0};
    rows[10] = '{100, 50, 100, 30, 50, 50};

    // one side stalls, the other runs.
    rows[11] = '{40, 20, 30, 100, 20, 20};
    rows[12] = '{40, 20, 100, 30, 20, 20};

    // mixed back-pressure.
    rows[13] = '{24, 10, 50, 50, 10, 14};
    rows[14] = '{16, 1, 30, 30, 1, 15};
    rows[15] = '{16, 15, 30, 30, 15, 1};
    rows[16] = '{12, 0, 100, 30, 0, 12};
    rows[17] = '{12, 12, 30, 100, 12, 0};
    rows[18] = '{2, 1, 50, 50, 1, 1};
    rows[19] = '{20, 7, 60, 40, 7, 13};
    rows[20] = '{9, 3, 100, 100, 3, 6};
endtask

`endif

/* tb_stream_split.sv */
`default_nettype none

module tb_stream_split
    import split_pkg::*;
();

    logic  clock;
    logic  rst_n;
    data_t origin_data;
    logic  origin_last;
    logic  origin_valid;
    logic  origin_ready;
    len_t  split_len;
    data_t first_data;
    logic  first_last;
    logic  first_valid;
    logic  first_ready;
    data_t end_data;
    logic  end_last;
    logic  end_valid;
    logic  end_ready;

    logic [31:0] lfsr_state;
    int          errors;
    int          checks;
    int          cycles;
    int          cycle_limit;
    int          idle_cycles;
    logic        timed_out;

    // expected beats per output, in order.
    data_t first_data_q [$];
    logic  first_last_q [$];
    data_t end_data_q [$];
    logic  end_last_q [$];
    int    first_row_q [$];  // rows that still owe beats on each side.
    int    end_row_q [$];
    len_t  first_beats;
    len_t  end_beats;

    int    row_idx;      // packet being offered.
    int    beat_idx;     // beat within that packet.
    logic  accepted;     // offered beat moves on the coming edge.
    logic  offer_first;  // offered beat belongs to the first stream.

    `include "tb_split_table.svh"

    stream_split_top UUT (
        .clock        (clock),
        .rst_n        (rst_n),
        .origin_data  (origin_data),
        .origin_last  (origin_last),
        .origin_valid (origin_valid),
        .origin_ready (origin_ready),
        .split_len    (split_len),
        .first_data   (first_data),
        .first_last   (first_last),
        .first_valid  (first_valid),
        .first_ready  (first_ready),
        .end_data     (end_data),
        .end_last     (end_last),
        .end_valid    (end_valid),
        .end_ready    (end_ready)
    );

    always #2 clock = ~clock;

    // fibonacci lfsr, taps 32 22 2 1, one step per bit taken.
    function automatic int take_bits(input int n);
        int   v;
        logic fb;
        v = 0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = (v << 1) | int'(fb);
        end
        return v;
    endfunction

    function automatic logic ready_roll(input int pct);
        int v;
        v = take_bits(7);
        return ((v * 100) / 128) < pct;
    endfunction

    function automatic string state_name();
        split_state_t s;
        s = UUT.split_inst.state;
        return s.name();
    endfunction

    task automatic check_data(input string name, input data_t exp, input data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at time %0t: %s expected %h, got %h (splitter in %s)",
                     $time, name, exp, act, state_name());
        end
    endtask

    task automatic check_last(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at time %0t: %s expected %b, got %b (splitter in %s)",
                     $time, name, exp, act, state_name());
        end
    endtask

    task automatic check_count(input string name, input len_t exp, input len_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at time %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    // offers the next beat once the last one moved, and books where it must land.
    task automatic drive_origin();
        int    len;
        int    sl;
        data_t beat_data;
        if (origin_valid && !accepted) begin
            return;  // hold until taken.
        end
        if (origin_valid && accepted) begin
            beat_idx++;
            if (beat_idx == rows[row_idx].pkt_len) begin
                row_idx++;
                beat_idx = 0;
            end
        end
        if (row_idx >= NUM_ROWS) begin
            origin_valid = 1'b0;
            return;
        end
        len = rows[row_idx].pkt_len;
        sl  = rows[row_idx].split;
        if (beat_idx == 0) begin
            if (sl > 0) first_row_q.push_back(row_idx);
            if (sl < len) end_row_q.push_back(row_idx);
            split_len = len_t'(sl);
        end else begin
            split_len = len_t'(take_bits(LEN_W));  // only the head beat carries the length.
        end
        beat_data    = data_t'(take_bits(8));
        origin_data  = beat_data;
        origin_last  = (beat_idx == len - 1);
        origin_valid = 1'b1;
        offer_first  = (sl > 0 && beat_idx < sl);
        if (offer_first) begin
            first_data_q.push_back(beat_data);
            first_last_q.push_back((beat_idx == sl - 1) || (beat_idx == len - 1));
        end else begin
            end_data_q.push_back(beat_data);
            end_last_q.push_back(beat_idx == len - 1);
        end
    endtask

    task automatic drive_ready();
        int first_pct;
        int end_pct;
        first_pct = (first_row_q.size() > 0) ? rows[first_row_q[0]].first_pct : 100;
        end_pct   = (end_row_q.size() > 0) ? rows[end_row_q[0]].end_pct : 100;
        first_ready = ready_roll(first_pct);
        end_ready   = ready_roll(end_pct);
    endtask

    task automatic take_first();
        int r;
        if (first_data_q.size() == 0) begin
            errors++;
            $display("first output delivered a beat at time %0t that was never sent", $time);
        end else begin
            check_data("first_data", first_data_q.pop_front(), first_data);
            check_last("first_last", first_last_q.pop_front(), first_last);
        end
        first_beats = first_beats + len_t'(1);
        if (first_last) begin
            if (first_row_q.size() == 0) begin
                errors++;
                $display("first output closed a packet at time %0t with none pending", $time);
            end else begin
                r = first_row_q.pop_front();
                check_count("first beat count", len_t'(rows[r].first_cnt), first_beats);
            end
            first_beats = '0;
        end
    endtask

    task automatic take_end();
        int r;
        if (end_data_q.size() == 0) begin
            errors++;
            $display("end output delivered a beat at time %0t that was never sent", $time);
        end else begin
            check_data("end_data", end_data_q.pop_front(), end_data);
            check_last("end_last", end_last_q.pop_front(), end_last);
        end
        end_beats = end_beats + len_t'(1);
        if (end_last) begin
            if (end_row_q.size() == 0) begin
                errors++;
                $display("end output closed a packet at time %0t with none pending", $time);
            end else begin
                r = end_row_q.pop_front();
                check_count("end beat count", len_t'(rows[r].end_cnt), end_beats);
            end
            end_beats = '0;
        end
    endtask

    // sampled between the falling and rising edge, so every handshake is settled.
    task automatic watch_outputs();
        logic ready_exp;
        accepted = origin_valid && origin_ready;
        // a side holds two beats at most; the offered beat is queued but not yet inside.
        ready_exp = offer_first ? (first_data_q.size() <= 2) : (end_data_q.size() <= 2);
        if (origin_valid) begin
            check_last("origin_ready", ready_exp, origin_ready);
        end
        if (first_valid && first_ready) take_first();
        if (end_valid && end_ready) take_end();
    endtask

    initial begin
        clock        = 1'b0;
        rst_n        = 1'b0;
        origin_data  = '0;
        origin_last  = 1'b0;
        origin_valid = 1'b0;
        split_len    = '0;
        first_ready  = 1'b1;
        end_ready    = 1'b1;
        lfsr_state   = 32'hb87c;
        errors       = 0;
        checks       = 0;
        cycles       = 0;
        idle_cycles  = 0;
        timed_out    = 1'b0;
        row_idx      = 0;
        beat_idx     = 0;
        accepted     = 1'b0;
        offer_first  = 1'b0;
        first_beats  = '0;
        end_beats    = '0;
        load_table();

        cycle_limit = 200;
        for (int i = 0; i < NUM_ROWS; i++) begin
            cycle_limit += 20 * rows[i].pkt_len;
        end

        // outputs stay quiet through reset and the cycle after.
        repeat (4) begin
            @(negedge clock);
            #1;
            check_last("first_valid", 1'b0, first_valid);
            check_last("end_valid", 1'b0, end_valid);
        end
        rst_n = 1'b1;
        @(negedge clock);
        #1;
        check_last("first_valid", 1'b0, first_valid);
        check_last("end_valid", 1'b0, end_valid);

        while (idle_cycles < 20) begin
            @(negedge clock);
            cycles++;
            if (cycles > cycle_limit) begin
                timed_out = 1'b1;
                break;
            end
            drive_origin();
            drive_ready();
            #1;
            watch_outputs();
            if (row_idx >= NUM_ROWS && first_data_q.size() == 0 && end_data_q.size() == 0)
                idle_cycles++;  // stray beats still get caught here.
        end

        if (timed_out) begin
            $display("run stopped after %0d cycles with beats still missing", cycle_limit);
        end
        if (first_data_q.size() != 0 || end_data_q.size() != 0) begin
            errors++;
            $display("beats left undelivered: %0d on first, %0d on end",
                     first_data_q.size(), end_data_q.size());
        end
        if (first_row_q.size() != 0 || end_row_q.size() != 0) begin
            errors++;
            $display("packets left unclosed: %0d on first, %0d on end",
                     first_row_q.size(), end_row_q.size());
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* stream_split_top.sv */
`default_nettype none

module stream_split_top
    import split_pkg::*;
(
    input  logic  clock,
    input  logic  rst_n,

    // incoming packets.
    input  data_t origin_data,
    input  logic  origin_last,
    input  logic  origin_valid,
    output logic  origin_ready,
    input  len_t  split_len,     // taken with the first beat of a packet.

    // head part of each packet.
    output data_t first_data,
    output logic  first_last,
    output logic  first_valid,
    input  logic  first_ready,

    // remaining part of each packet.
    output data_t end_data,
    output logic  end_last,
    output logic  end_valid,
    input  logic  end_ready
);

    // raw streams between the splitter and the skid buffers.
    axis_beat_if first_raw ();
    axis_beat_if end_raw ();

    stream_split_channel split_inst (
        .clock        (clock),
        .rst_n        (rst_n),
        .origin_data  (origin_data),
        .origin_last  (origin_last),
        .origin_valid (origin_valid),
        .origin_ready (origin_ready),
        .split_len    (split_len),
        .first_out    (first_raw.source),
        .end_out      (end_raw.source)
    );

    // each side stalls on its own.
    axis_skid_buffer first_skid (
        .clock     (clock),
        .rst_n     (rst_n),
        .in        (first_raw.sink),
        .out_data  (first_data),
        .out_last  (first_last),
        .out_valid (first_valid),
        .out_ready (first_ready)
    );

    axis_skid_buffer end_skid (
        .clock     (clock),
        .rst_n     (rst_n),
        .in        (end_raw.sink),
        .out_data  (end_data),
        .out_last  (end_last),
        .out_valid (end_valid),
        .out_ready (end_ready)
    );

endmodule

`default_nettype wire

/* axis_skid_buffer.sv */
`default_nettype none

module axis_skid_buffer
    import split_pkg::*;
(
    input  logic      clock,
    input  logic      rst_n,

    axis_beat_if.sink in,

    output data_t     out_data,
    output logic      out_last,
    output logic      out_valid,
    input  logic      out_ready
);

    data_t skid_data;   // beat caught while the output stalls.
    logic  skid_last;
    logic  skid_valid;

    logic  in_ready_q;  // registered ready toward the source.
    logic  accept;      // input beat moves this cycle.
    logic  main_load;   // main register empty or draining.
    logic  skid_next;   // skid holds a beat after this edge.

    assign in.ready  = in_ready_q;
    assign accept    = in.valid && in_ready_q;
    assign main_load = !out_valid || out_ready;

    // skid only fills behind a main beat that is not leaving.
    // ready is low while skid holds a beat, so accept and skid_valid
    // never meet.
    assign skid_next = (skid_valid || accept) && !main_load;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
            in_ready_q <= 1'b1;  // empty after reset.
        end else begin
            skid_valid <= skid_next;
            in_ready_q <= !skid_next;  // low only with both entries full.
            if (main_load) begin
                out_valid <= skid_valid || accept;
            end
        end
    end

    // main register takes the skid beat first to keep the order.
    always_ff @(posedge clock) begin
        if (main_load) begin
            if (skid_valid) begin
                out_data <= skid_data;
                out_last <= skid_last;
            end else if (accept) begin
                out_data <= in.data;
                out_last <= in.last;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept && !main_load) begin
            skid_data <= in.data;  // output stalled, park the beat.
            skid_last <= in.last;
        end
    end

endmodule

`default_nettype wire

/* stream_split_channel.sv */
`default_nettype none

module stream_split_channel
    import split_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,

    input  data_t       origin_data,
    input  logic        origin_last,
    input  logic        origin_valid,
    output logic        origin_ready,
    input  len_t        split_len,     // sampled with the head beat.

    axis_beat_if.source first_out,
    axis_beat_if.source end_out
);

    split_state_t state;      // phase of the current packet.
    len_t         split_q;    // split length held for the packet.
    len_t         first_cnt;  // beats already sent to the first stream.

    len_t cur_len;            // split length that applies to this beat.
    logic route_first;        // current beat goes to the first stream.
    logic first_last;         // current beat closes the first part.
    logic accept;             // origin beat moves this cycle.

    // on the head beat the latched length is not there yet,
    // so the input is used directly.
    always_comb begin
        if (state == SPLIT_HEAD) begin
            cur_len     = split_len;
            route_first = (split_len != '0);  // zero sends it all to the end side.
        end else begin
            cur_len     = split_q;
            route_first = (state == SPLIT_FIRST);
        end
    end

    // first part ends at the split point, or earlier with the packet.
    assign first_last = origin_last || (first_cnt == len_t'(cur_len - len_t'(1)));

    // data goes to both sides, valid only to the chosen one.
    assign first_out.data  = origin_data;
    assign first_out.last  = first_last;
    assign first_out.valid = origin_valid && route_first;

    assign end_out.data    = origin_data;
    assign end_out.last    = origin_last;  // the packet keeps its own last.
    assign end_out.valid   = origin_valid && !route_first;

    // the idle side never stalls the origin.
    assign origin_ready = route_first ? first_out.ready : end_out.ready;

    assign accept = origin_valid && origin_ready;

    // phase and beat count.
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state     <= SPLIT_HEAD;
            first_cnt <= '0;
        end else if (accept) begin
            if (origin_last) begin
                state     <= SPLIT_HEAD;  // next beat starts a new packet.
                first_cnt <= '0;
            end else if (route_first) begin
                if (first_last) begin
                    state     <= SPLIT_END;  // split point reached.
                    first_cnt <= '0;
                end else begin
                    state     <= SPLIT_FIRST;
                    first_cnt <= len_t'(first_cnt + len_t'(1));
                end
            end else begin
                state <= SPLIT_END;  // rest of the packet, till its last.
            end
        end
    end

    // split length is only read after the head beat has set it.
    always_ff @(posedge clock) begin
        if (accept && (state == SPLIT_HEAD)) begin
            split_q <= split_len;
        end
    end

endmodule

`default_nettype wire

/* axis_beat_if.sv */
`default_nettype none

// one byte stream with a valid/ready handshake.
// a beat moves on a rising edge where valid and ready are both high.
interface axis_beat_if
    import split_pkg::*;
();

    data_t data;   // beat payload.
    logic  last;   // closes a packet.
    logic  valid;  // source offers a beat.
    logic  ready;  // sink takes the beat.

    // the side that produces beats.
    modport source (
        output data,
        output last,
        output valid,
        input  ready
    );

    // the side that consumes beats.
    modport sink (
        input  data,
        input  last,
        input  valid,
        output ready
    );

endinterface

`default_nettype wire

/* split_pkg.sv */
`default_nettype none

package split_pkg;

    // one stream beat carries a single byte.
    localparam int DATA_W = 8;

    // split lengths and beat counters share this width.
    localparam int LEN_W = 16;

    typedef logic [DATA_W-1:0] data_t;  // payload of one beat.
    typedef logic [LEN_W-1:0]  len_t;   // split length or beat index.

    // phase of the packet that currently sits on the origin stream.
    // a packet always starts in SPLIT_HEAD, so the split length of the
    // new packet can be taken straight from the input on that beat.
    typedef enum logic [1:0] {
        SPLIT_HEAD  = 2'd0,  // waiting for the first beat.
        SPLIT_FIRST = 2'd1,  // routing to the first stream.
        SPLIT_END   = 2'd2   // routing to the end stream.
    } split_state_t;

endpackage

`default_nettype wire
